//--- hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // 800x600 at 60 Hz, 40 MHz pixel clock.
  localparam int H_ACTIVE = 800;
  localparam int H_FP     = 40;
  localparam int H_SYNC   = 128;
  localparam int H_TOTAL  = 1056;

  localparam int V_ACTIVE = 600;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 4;
  localparam int V_TOTAL  = 628;

  // wide enough for the longer of the two counts.
  localparam int CNT_W = $clog2(H_TOTAL);

  // 4 bits per channel.
  localparam int RGB_W = 12;

  localparam logic [RGB_W-1:0] BLANK_RGB = '0; // black during blanking.

endpackage

`default_nettype wire

//--- hdl/font_pkg.sv
`default_nettype none

package font_pkg;

  localparam int CODE_W  = 7;
  localparam int GLYPH_W = 8;
  localparam int GLYPH_H = 8;
  localparam int GRID    = 16; // characters per row and rows per window.

  // top-left pixel of the 128x128 window.
  localparam int TEXT_X = 336;
  localparam int TEXT_Y = 236;

  // ascii codes.
  localparam logic [CODE_W-1:0] SPC = 7'h20;
  localparam logic [CODE_W-1:0] K   = 7'h4b;
  localparam logic [CODE_W-1:0] O   = 7'h4f;
  localparam logic [CODE_W-1:0] N   = 7'h4e;
  localparam logic [CODE_W-1:0] I   = 7'h49;
  localparam logic [CODE_W-1:0] E   = 7'h45;
  localparam logic [CODE_W-1:0] C   = 7'h43;
  localparam logic [CODE_W-1:0] M   = 7'h4d;
  localparam logic [CODE_W-1:0] S   = 7'h53;
  localparam logic [CODE_W-1:0] i   = 7'h69;
  localparam logic [CODE_W-1:0] k   = 7'h6b;
  localparam logic [CODE_W-1:0] o   = 7'h6f;
  localparam logic [CODE_W-1:0] l   = 7'h6c;
  localparam logic [CODE_W-1:0] a   = 7'h61;
  localparam logic [CODE_W-1:0] j   = 7'h6a;
  localparam logic [CODE_W-1:0] u   = 7'h75;
  localparam logic [CODE_W-1:0] p   = 7'h70;
  localparam logic [CODE_W-1:0] s   = 7'h73;

  // solid block, drawn along the bottom row.
  localparam logic [CODE_W-1:0] BAR = 7'h0e;

endpackage

`default_nettype wire

//--- hdl/vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

module vga_timing (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [vga_pkg::CNT_W-1:0] hcount,
  output logic [vga_pkg::CNT_W-1:0] vcount,
  output logic                      hsync,
  output logic                      vsync,
  output logic                      blank
);

  logic [vga_pkg::CNT_W-1:0] hcount_nxt;
  logic [vga_pkg::CNT_W-1:0] vcount_nxt;
  logic                      h_wrap;
  logic                      v_wrap;

  // decode from the next count so the flags line up with the counters.
  always_comb begin
    h_wrap     = (int'(hcount) == vga_pkg::H_TOTAL - 1);
    v_wrap     = (int'(vcount) == vga_pkg::V_TOTAL - 1);
    hcount_nxt = h_wrap ? '0 : hcount + 1'b1;
    vcount_nxt = vcount;
    if (h_wrap) begin
      vcount_nxt = v_wrap ? '0 : vcount + 1'b1; // new line.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      blank  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= (int'(hcount_nxt) >= vga_pkg::H_ACTIVE + vga_pkg::H_FP) &&
                (int'(hcount_nxt) <  vga_pkg::H_ACTIVE + vga_pkg::H_FP + vga_pkg::H_SYNC);
      vsync  <= (int'(vcount_nxt) >= vga_pkg::V_ACTIVE + vga_pkg::V_FP) &&
                (int'(vcount_nxt) <  vga_pkg::V_ACTIVE + vga_pkg::V_FP + vga_pkg::V_SYNC);
      blank  <= (int'(hcount_nxt) >= vga_pkg::H_ACTIVE) ||
                (int'(vcount_nxt) >= vga_pkg::V_ACTIVE);
    end
  end

  // counters never leave the frame.
  a_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (int'(hcount) < vga_pkg::H_TOTAL) && (int'(vcount) < vga_pkg::V_TOTAL)
  ) else $error("vga_timing: counter out of range h=%0d v=%0d", hcount, vcount);

endmodule

`default_nettype wire

//--- hdl/char_rom_16x16_koniec.sv
`timescale 1ns/100ps
`default_nettype none

module char_rom_16x16_koniec (
  input  logic [7:0]                  char_xy,
  output logic [font_pkg::CODE_W-1:0] char_code
);

  // upper nibble is the row, lower nibble the column.
  always_comb begin
    case (char_xy)
      8'h05: char_code = font_pkg::K;
      8'h06: char_code = font_pkg::O;
      8'h07: char_code = font_pkg::N;
      8'h08: char_code = font_pkg::I;
      8'h09: char_code = font_pkg::E;
      8'h0a: char_code = font_pkg::C;

      8'h10: char_code = font_pkg::M;
      8'h11: char_code = font_pkg::i;
      8'h12: char_code = font_pkg::k;
      8'h13: char_code = font_pkg::o;
      8'h14: char_code = font_pkg::l;
      8'h15: char_code = font_pkg::a;
      8'h16: char_code = font_pkg::j;
      8'h18: char_code = font_pkg::S;
      8'h19: char_code = font_pkg::l;
      8'h1a: char_code = font_pkg::u;
      8'h1b: char_code = font_pkg::p;
      8'h1c: char_code = font_pkg::s;
      8'h1d: char_code = font_pkg::k;
      8'h1e: char_code = font_pkg::i;

      // bottom row is a solid bar.
      8'hf0, 8'hf1, 8'hf2, 8'hf3,
      8'hf4, 8'hf5, 8'hf6, 8'hf7,
      8'hf8, 8'hf9, 8'hfa, 8'hfb,
      8'hfc, 8'hfd, 8'hfe, 8'hff: char_code = font_pkg::BAR;

      default: char_code = font_pkg::SPC;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/font_rom.sv
`timescale 1ns/100ps
`default_nettype none

module font_rom (
  input  logic [font_pkg::CODE_W-1:0]  char_code,
  input  logic [2:0]                   glyph_row,
  output logic [font_pkg::GLYPH_W-1:0] glyph_bits
);

  // one 64-bit word per glyph.
  logic [font_pkg::GLYPH_W*font_pkg::GLYPH_H-1:0] glyph_mem [2**font_pkg::CODE_W];
  logic [font_pkg::GLYPH_W*font_pkg::GLYPH_H-1:0] glyph_word;

  initial begin
    $readmemh("hdl/font.mem", glyph_mem);
  end

  assign glyph_word = glyph_mem[char_code];

  // row 0 sits in the top byte.
  assign glyph_bits =
    glyph_word[(3'd7 - glyph_row) * font_pkg::GLYPH_W +: font_pkg::GLYPH_W];

endmodule

`default_nettype wire

//--- hdl/text_overlay.sv
`timescale 1ns/100ps
`default_nettype none

module text_overlay (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [vga_pkg::CNT_W-1:0] hcount,
  input  logic [vga_pkg::CNT_W-1:0] vcount,
  input  logic                      hsync,
  input  logic                      vsync,
  input  logic                      blank,
  input  logic [vga_pkg::RGB_W-1:0] fg_rgb,
  input  logic [vga_pkg::RGB_W-1:0] bg_rgb,
  output logic [vga_pkg::RGB_W-1:0] rgb,
  output logic                      hsync_out,
  output logic                      vsync_out
);

  logic [vga_pkg::CNT_W-1:0]    win_x;
  logic [vga_pkg::CNT_W-1:0]    win_y;
  logic                         in_win;
  logic [7:0]                   char_xy;
  logic [font_pkg::CODE_W-1:0]  char_code;
  logic [font_pkg::CODE_W-1:0]  char_code_q;
  logic [2:0]                   glyph_row_q;
  logic [2:0]                   glyph_col_q;
  logic [vga_pkg::RGB_W-1:0]    fg_q;
  logic [vga_pkg::RGB_W-1:0]    bg_q;
  logic                         in_win_q;
  logic                         blank_q;
  logic                         hsync_q;
  logic                         vsync_q;
  logic [font_pkg::GLYPH_W-1:0] glyph_bits;

  // offsets wrap to large values left of and above the window.
  assign win_x   = hcount - font_pkg::TEXT_X[vga_pkg::CNT_W-1:0];
  assign win_y   = vcount - font_pkg::TEXT_Y[vga_pkg::CNT_W-1:0];
  assign in_win  = (int'(win_x) < font_pkg::GRID * font_pkg::GLYPH_W) &&
                   (int'(win_y) < font_pkg::GRID * font_pkg::GLYPH_H);
  assign char_xy = {win_y[6:3], win_x[6:3]};

  char_rom_16x16_koniec u_char_rom (
    .char_xy   (char_xy),
    .char_code (char_code)
  );

  // stage 1 flags.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_win_q <= 1'b0;
      blank_q  <= 1'b0;
      hsync_q  <= 1'b0;
      vsync_q  <= 1'b0;
    end else begin
      in_win_q <= in_win;
      blank_q  <= blank;
      hsync_q  <= hsync;
      vsync_q  <= vsync;
    end
  end

  always_ff @(posedge clk) begin
    char_code_q <= char_code;
    glyph_row_q <= win_y[2:0];
    glyph_col_q <= win_x[2:0];
    fg_q        <= fg_rgb; // colours follow their pixel.
    bg_q        <= bg_rgb;
  end

  font_rom u_font_rom (
    .char_code  (char_code_q),
    .glyph_row  (glyph_row_q),
    .glyph_bits (glyph_bits)
  );

  // stage 2, pixel colour.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb       <= '0;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
    end else begin
      hsync_out <= hsync_q;
      vsync_out <= vsync_q;
      if (blank_q) begin
        rgb <= vga_pkg::BLANK_RGB;
      end else if (in_win_q) begin
        rgb <= glyph_bits[3'd7 - glyph_col_q] ? fg_q : bg_q; // msb is leftmost.
      end else begin
        rgb <= '0;
      end
    end
  end

  // text window sits inside the active area.
  a_win_active: assert property (
    @(posedge clk) disable iff (!rst_n) in_win |-> !blank
  ) else $error("text_overlay: text window reaches into blanking");

endmodule

`default_nettype wire

//--- hdl/vga_text_top.sv
`timescale 1ns/100ps
`default_nettype none

module vga_text_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [vga_pkg::RGB_W-1:0] fg_rgb,
  input  logic [vga_pkg::RGB_W-1:0] bg_rgb,
  output logic                      hsync,
  output logic                      vsync,
  output logic [vga_pkg::RGB_W-1:0] rgb
);

  logic [vga_pkg::CNT_W-1:0] hcount;
  logic [vga_pkg::CNT_W-1:0] vcount;
  logic                      hsync_tim;
  logic                      vsync_tim;
  logic                      blank;

  vga_timing u_vga_timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .hcount (hcount),
    .vcount (vcount),
    .hsync  (hsync_tim),
    .vsync  (vsync_tim),
    .blank  (blank)
  );

  // syncs are delayed here to match the pixel pipeline.
  text_overlay u_text_overlay (
    .clk       (clk),
    .rst_n     (rst_n),
    .hcount    (hcount),
    .vcount    (vcount),
    .hsync     (hsync_tim),
    .vsync     (vsync_tim),
    .blank     (blank),
    .fg_rgb    (fg_rgb),
    .bg_rgb    (bg_rgb),
    .rgb       (rgb),
    .hsync_out (hsync),
    .vsync_out (vsync)
  );

endmodule

`default_nettype wire

//--- test/tb_vga_text.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vga_text;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int SEED            = 21242;
  localparam int FRAME_CYCLES    = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
  localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + 1000;
  localparam int WIN_W           = font_pkg::GRID * font_pkg::GLYPH_W;
  localparam int WIN_H           = font_pkg::GRID * font_pkg::GLYPH_H;

  logic                      clk;
  logic                      rst_n;
  logic [vga_pkg::RGB_W-1:0] fg_rgb;
  logic [vga_pkg::RGB_W-1:0] bg_rgb;
  logic                      hsync;
  logic                      vsync;
  logic [vga_pkg::RGB_W-1:0] rgb;

  // reference copies of the message and the font.
  logic [font_pkg::CODE_W-1:0] msg [font_pkg::GRID][font_pkg::GRID];
  logic [63:0]                 font_words [2**font_pkg::CODE_W];

  logic [vga_pkg::RGB_W-1:0] fg_hist [2];
  logic [vga_pkg::RGB_W-1:0] bg_hist [2];

  int   errors;
  int   checks;
  int   hold_left;
  int   since_release;
  int   low_left;
  bit   synced;
  int   mh;
  int   mv;
  logic hsync_prev;
  logic vsync_prev;
  bit   hs_seen;
  int   hs_since;
  int   hs_high;
  int   vs_high;
  int   reset_gap;

  vga_text_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .fg_rgb (fg_rgb),
    .bg_rgb (bg_rgb),
    .hsync  (hsync),
    .vsync  (vsync),
    .rgb    (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  function automatic bit in_window(input int h, input int v);
    return (h >= font_pkg::TEXT_X) && (h < font_pkg::TEXT_X + WIN_W) &&
           (v >= font_pkg::TEXT_Y) && (v < font_pkg::TEXT_Y + WIN_H);
  endfunction

  function automatic logic [vga_pkg::RGB_W-1:0] pixel_colour(
    input int h, input int v,
    input logic [vga_pkg::RGB_W-1:0] fg, input logic [vga_pkg::RGB_W-1:0] bg);
    int                          dx;
    int                          dy;
    logic [font_pkg::CODE_W-1:0] code;
    logic [63:0]                 word;
    logic [7:0]                  bits;
    dx = h - font_pkg::TEXT_X;
    dy = v - font_pkg::TEXT_Y;
    if (h >= vga_pkg::H_ACTIVE || v >= vga_pkg::V_ACTIVE) begin
      return vga_pkg::BLANK_RGB;
    end
    if (!in_window(h, v)) begin
      return '0;
    end
    code = msg[4'(dy / font_pkg::GLYPH_H)][4'(dx / font_pkg::GLYPH_W)];
    word = font_words[code];
    bits = 8'(word >> (8 * (7 - dy % font_pkg::GLYPH_H))); // row 0 is the top byte.
    return bits[3'(7 - dx % font_pkg::GLYPH_W)] ? fg : bg;
  endfunction

  task automatic load_message();
    for (int r = 0; r < font_pkg::GRID; r++) begin
      for (int c = 0; c < font_pkg::GRID; c++) begin
        msg[4'(r)][4'(c)] = (r == font_pkg::GRID - 1) ? font_pkg::BAR : font_pkg::SPC;
      end
    end
    msg[0][5]  = font_pkg::K;
    msg[0][6]  = font_pkg::O;
    msg[0][7]  = font_pkg::N;
    msg[0][8]  = font_pkg::I;
    msg[0][9]  = font_pkg::E;
    msg[0][10] = font_pkg::C;
    msg[1][0]  = font_pkg::M;
    msg[1][1]  = font_pkg::i;
    msg[1][2]  = font_pkg::k;
    msg[1][3]  = font_pkg::o;
    msg[1][4]  = font_pkg::l;
    msg[1][5]  = font_pkg::a;
    msg[1][6]  = font_pkg::j;
    msg[1][8]  = font_pkg::S;
    msg[1][9]  = font_pkg::l;
    msg[1][10] = font_pkg::u;
    msg[1][11] = font_pkg::p;
    msg[1][12] = font_pkg::s;
    msg[1][13] = font_pkg::k;
    msg[1][14] = font_pkg::i;
  endtask

  // new colours every 1 to 64 cycles.
  task automatic drive_colours();
    logic [31:0] rnd;
    if (hold_left == 0) begin
      rnd       = $urandom;
      fg_rgb    = rnd[vga_pkg::RGB_W-1:0];
      rnd       = $urandom;
      bg_rgb    = rnd[vga_pkg::RGB_W-1:0];
      rnd       = $urandom;
      hold_left = int'(rnd % 64) + 1;
    end
    hold_left--;
    fg_hist[1] = fg_hist[0];
    fg_hist[0] = fg_rgb;
    bg_hist[1] = bg_hist[0];
    bg_hist[0] = bg_rgb;
  endtask

  task automatic track_pulses();
    hs_since++;
    if (hsync === 1'b1) hs_high++;
    if (vsync === 1'b1) vs_high++;
    if (hsync === 1'b1 && hsync_prev === 1'b0) begin
      if (hs_seen) compare("hsync_period", vga_pkg::H_TOTAL, hs_since);
      hs_seen  = 1'b1;
      hs_since = 0;
    end
    if (hsync === 1'b0 && hsync_prev === 1'b1) begin
      compare("hsync_width", vga_pkg::H_SYNC, hs_high);
      hs_high = 0;
    end
    if (vsync === 1'b0 && vsync_prev === 1'b1) begin
      compare("vsync_width", vga_pkg::V_SYNC * vga_pkg::H_TOTAL, vs_high);
      vs_high = 0;
    end
  endtask

  task automatic check_outputs();
    logic                      exp_hs;
    logic                      exp_vs;
    logic [vga_pkg::RGB_W-1:0] exp_rgb;
    string                     region;
    since_release++;
    track_pulses();
    if (low_left > 0) begin
      compare("post_reset_hsync", 32'd0, 32'(hsync));
      compare("post_reset_vsync", 32'd0, 32'(vsync));
      compare("post_reset_rgb", 32'd0, 32'(rgb));
      low_left--;
    end
    if (synced) begin
      mh++;
      if (mh == vga_pkg::H_TOTAL) begin
        mh = 0;
        mv++;
        if (mv == vga_pkg::V_TOTAL) mv = 0;
      end
    end else if (vsync === 1'b1 && vsync_prev === 1'b0) begin
      synced = 1'b1; // first line of the vsync pulse.
      mh     = 0;
      mv     = vga_pkg::V_ACTIVE + vga_pkg::V_FP;
      compare("vsync_first_rise", mv * vga_pkg::H_TOTAL + 2, since_release);
    end
    if (synced) begin
      exp_hs = (mh >= vga_pkg::H_ACTIVE + vga_pkg::H_FP) &&
               (mh < vga_pkg::H_ACTIVE + vga_pkg::H_FP + vga_pkg::H_SYNC);
      exp_vs = (mv >= vga_pkg::V_ACTIVE + vga_pkg::V_FP) &&
               (mv < vga_pkg::V_ACTIVE + vga_pkg::V_FP + vga_pkg::V_SYNC);
      compare("hsync", 32'(exp_hs), 32'(hsync));
      compare("vsync", 32'(exp_vs), 32'(vsync));
      exp_rgb = pixel_colour(mh, mv, fg_hist[1], bg_hist[1]);
      if (mh >= vga_pkg::H_ACTIVE || mv >= vga_pkg::V_ACTIVE) region = "rgb_blank";
      else if (in_window(mh, mv)) region = "rgb_window";
      else region = "rgb_outside";
      compare(region, 32'(exp_rgb), 32'(rgb));
    end
    hsync_prev = hsync;
    vsync_prev = vsync;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      check_outputs();
      drive_colours();
    end
  endtask

  task automatic apply_reset();
    rst_n      = 1'b0;
    synced     = 1'b0;
    hsync_prev = 1'b0;
    vsync_prev = 1'b0;
    hs_seen    = 1'b0;
    hs_since   = 0;
    hs_high    = 0;
    vs_high    = 0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compare("reset_hsync", 32'd0, 32'(hsync));
      compare("reset_vsync", 32'd0, 32'(vsync));
      compare("reset_rgb", 32'd0, 32'(rgb));
      drive_colours();
    end
    rst_n         = 1'b1;
    since_release = 0;
    low_left      = RESET_CYCLES;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    fg_rgb     = '0;
    bg_rgb     = '0;
    fg_hist[0] = '0;
    fg_hist[1] = '0;
    bg_hist[0] = '0;
    bg_hist[1] = '0;
    errors     = 0;
    checks     = 0;
    hold_left  = 0;
    low_left   = 0;
    mh         = 0;
    mv         = 0;
    load_message();
    $readmemh("hdl/font.mem", font_words);
    apply_reset();
    // mid-run reset lands after the window of frame 2.
    reset_gap = FRAME_CYCLES + (370 + int'($urandom % 61)) * vga_pkg::H_TOTAL +
                int'($urandom % vga_pkg::H_TOTAL);
    run_cycles(reset_gap);
    apply_reset();
    run_cycles(FRAME_CYCLES);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/font.mem
// one 64-bit glyph word per line for codes 00 to 7f.
// row 0 is the top byte and bit 7 is the leftmost pixel.
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
ffffffffffffffff // 0e bar
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000 // 20 space
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
3c66606060663c00 // 43 C
0000000000000000
7e60607860607e00 // 45 E
0000000000000000
0000000000000000
0000000000000000
3c18181818183c00 // 49 I
0000000000000000
666c7870786c6600 // 4b K
0000000000000000
63777f6b63636300 // 4d M
66767e7e6e666600 // 4e N
3c66666666663c00 // 4f O
0000000000000000
0000000000000000
0000000000000000
3c66603c06663c00 // 53 S
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
00003c063e663e00 // 61 a
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
1800381818183c00 // 69 i
0600060606663c00 // 6a j
6060666c786c6600 // 6b k
3818181818183c00 // 6c l
0000000000000000
0000000000000000
00003c6666663c00 // 6f o
00007c66667c6060 // 70 p
0000000000000000
0000000000000000
00003e603c067c00 // 73 s
0000000000000000
0000666666663e00 // 75 u
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
0000000000000000

//--- all.f
hdl/vga_pkg.sv
hdl/font_pkg.sv
hdl/vga_timing.sv
hdl/char_rom_16x16_koniec.sv
hdl/font_rom.sv
hdl/text_overlay.sv
hdl/vga_text_top.sv
test/tb_vga_text.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_vga_text -f all.f
sim_out=$(./obj_dir/Vtb_vga_text)
echo "$sim_out"
grep -q "^test passed$" <<< "$sim_out"
